/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = io_read_tb
FILE_LIST = io_read.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* io_read.f */
rtl/io_map_pkg.sv
rtl/io_types_pkg.sv
rtl/read_req_if.sv
rtl/read_port_decode.sv
rtl/data_ram.sv
rtl/read_port_select.sv
rtl/read_output_stage.sv
rtl/io_read_top.sv
verif/io_read_monitor.sv
verif/io_read_chk.sv
verif/io_read_tb.sv

/* rtl/data_ram.sv */
// ========================================
// Local data RAM
// ========================================

module data_ram (
    input  logic                clock,
    input  logic                write,
    input  io_types_pkg::addr_t write_addr,
    input  io_types_pkg::word_t write_data,
    input  io_types_pkg::addr_t read_addr,
    output io_types_pkg::word_t read_data
);
    import io_map_pkg::*;
    import io_types_pkg::*;

    word_t mem [0:(2**addr_width)-1];  // one word per address.

    // ========================================
    // Write port
    // ========================================

    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_addr] <= write_data;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // The read samples the array before any write on the same edge lands,
    // so a read and a write to one address return the old word.
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];  // registered read, ready one cycle later.
    end

endmodule

/* rtl/io_map_pkg.sv */
// ========================================
// I/O read address map
// ========================================

package io_map_pkg;

    // ========================================
    // Data path widths
    // ========================================

    localparam int word_width = 16;       // one data word.
    localparam int addr_width = 10;       // covers the full 1024 word RAM.

    // ========================================
    // Read port window
    // ========================================

    localparam int port_count      = 4;   // external read ports.
    localparam int port_addr_width = 2;   // bits needed to index a port.

    // The window sits at the very top of the address space and shadows the RAM there.
    localparam logic [addr_width-1:0] port_base_addr = 1020;

    localparam int read_latency = 2;      // address in to data out, in cycles.

endpackage

/* rtl/io_read_top.sv */
// ========================================
// Memory-mapped I/O read path
// ========================================

module io_read_top (
    input  logic                                                clock,
    input  logic                                                rst_n,
    input  logic                                                read_valid,
    input  io_types_pkg::addr_t                                 read_addr,
    input  logic                                                io_ready,
    input  io_types_pkg::port_mask_t                            port_full,
    input  logic [io_map_pkg::port_count*io_map_pkg::word_width-1:0] port_data,
    input  logic                                                ram_write,
    input  io_types_pkg::addr_t                                 ram_write_addr,
    input  io_types_pkg::word_t                                 ram_write_data,
    output logic                                                port_ready_masked,
    output io_types_pkg::port_mask_t                            port_read,
    output io_types_pkg::word_t                                 read_data,
    output logic                                                read_data_valid
);
    import io_types_pkg::*;

    word_t        ram_data;      // RAM word for the request in flight.
    logic         stage_valid;
    read_source_e stage_source;
    logic         stage_gated;
    word_t        io_word;
    word_t        ram_word;

    read_req_if req_bus ();

    read_port_decode u_decode (
        .clock             (clock),
        .rst_n             (rst_n),
        .read_valid        (read_valid),
        .read_addr         (read_addr),
        .io_ready          (io_ready),
        .port_full         (port_full),
        .port_ready_masked (port_ready_masked),
        .req               (req_bus.decode)
    );

    // The RAM sees the raw address so its word arrives with the decoded request.
    data_ram u_ram (
        .clock      (clock),
        .write      (ram_write),
        .write_addr (ram_write_addr),
        .write_data (ram_write_data),
        .read_addr  (read_addr),
        .read_data  (ram_data)
    );

    read_port_select u_select (
        .req          (req_bus.select),
        .port_data    (port_data),
        .ram_data     (ram_data),
        .port_read    (port_read),
        .stage_valid  (stage_valid),
        .stage_source (stage_source),
        .stage_gated  (stage_gated),
        .io_word      (io_word),
        .ram_word     (ram_word)
    );

    read_output_stage u_output (
        .clock           (clock),
        .rst_n           (rst_n),
        .stage_valid     (stage_valid),
        .stage_source    (stage_source),
        .stage_gated     (stage_gated),
        .io_word         (io_word),
        .ram_word        (ram_word),
        .read_data       (read_data),
        .read_data_valid (read_data_valid)
    );

endmodule

/* rtl/io_types_pkg.sv */
// ========================================
// I/O read shared types
// ========================================

package io_types_pkg;

    typedef logic [io_map_pkg::word_width-1:0] word_t;             // a data word.
    typedef logic [io_map_pkg::addr_width-1:0] addr_t;             // a read or write address.
    typedef logic [io_map_pkg::port_addr_width-1:0] port_index_t;  // a port number.
    typedef logic [io_map_pkg::port_count-1:0] port_mask_t;        // one bit per port.

    // Where a read takes its word from.
    typedef enum logic {
        source_ram = 1'b0,  // local data RAM.
        source_io  = 1'b1   // one of the external read ports.
    } read_source_e;

endpackage

/* rtl/read_output_stage.sv */
// ========================================
// Read result register
// ========================================

module read_output_stage (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       stage_valid,
    input  io_types_pkg::read_source_e stage_source,
    input  logic                       stage_gated,
    input  io_types_pkg::word_t        io_word,
    input  io_types_pkg::word_t        ram_word,
    output io_types_pkg::word_t        read_data,
    output logic                       read_data_valid
);
    import io_types_pkg::*;

    // ========================================
    // Result word
    // ========================================

    always_ff @(posedge clock) begin
        if (stage_gated) begin
            read_data <= '0;         // a held back read returns zero.
        end else if (stage_source == source_io) begin
            read_data <= io_word;
        end else begin
            read_data <= ram_word;
        end
    end

    // ========================================
    // Valid pulse
    // ========================================

    // One pulse per request, two cycles after the address.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            read_data_valid <= 1'b0;
        end else begin
            read_data_valid <= stage_valid;
        end
    end

endmodule

/* rtl/read_port_decode.sv */
// ========================================
// Read address decode
// ========================================

module read_port_decode (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    read_valid,
    input  io_types_pkg::addr_t     read_addr,
    input  logic                    io_ready,
    input  io_types_pkg::port_mask_t port_full,
    output logic                    port_ready_masked,
    read_req_if.decode              req
);
    import io_map_pkg::*;
    import io_types_pkg::*;

    logic        in_window;
    port_index_t port_index;

    // ========================================
    // Window decode
    // ========================================

    // The window is aligned to port_count, so only the upper bits need comparing.
    assign in_window = (read_addr[addr_width-1:port_addr_width] ==
                        port_base_addr[addr_width-1:port_addr_width]);

    assign port_index = read_addr[port_addr_width-1:0];  // low bits pick the port.

    // Outside the window a read never waits, so the flag reads as ready.
    always_comb begin
        if (in_window) begin
            port_ready_masked = port_full[port_index];
        end else begin
            port_ready_masked = 1'b1;
        end
    end

    // ========================================
    // Request register
    // ========================================

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= read_valid;  // one request per accepted read.
        end
    end

    always_ff @(posedge clock) begin
        if (in_window) begin
            req.source <= source_io;
        end else begin
            req.source <= source_ram;
        end
        req.port     <= port_index;
        req.ram_addr <= read_addr;
        req.gated    <= !io_ready;    // the scheduler held this read back.
    end

endmodule

/* rtl/read_port_select.sv */
// ========================================
// Port strobe and word select
// ========================================

module read_port_select (
    read_req_if.select                                          req,
    input  logic [io_map_pkg::port_count*io_map_pkg::word_width-1:0] port_data,
    input  io_types_pkg::word_t                                 ram_data,
    output io_types_pkg::port_mask_t                            port_read,
    output logic                                                stage_valid,
    output io_types_pkg::read_source_e                          stage_source,
    output logic                                                stage_gated,
    output io_types_pkg::word_t                                 io_word,
    output io_types_pkg::word_t                                 ram_word
);
    import io_map_pkg::*;
    import io_types_pkg::*;

    logic        strobe_en;
    port_index_t data_index;

    // ========================================
    // Port read strobe
    // ========================================

    // A port is popped only for a live, ungated read inside the window.
    assign strobe_en = req.valid && (req.source == source_io) && !req.gated;

    always_comb begin
        port_read = '0;
        if (strobe_en) begin
            port_read[req.port] = 1'b1;  // one-hot on the addressed port.
        end
    end

    // ========================================
    // Word select
    // ========================================

    // The low address bits index the port because the window is aligned.
    assign data_index = req.ram_addr[port_addr_width-1:0];

    // The word is taken while the strobe is high, before the port pops it.
    assign io_word = port_data[data_index*word_width +: word_width];

    assign ram_word = ram_data;  // RAM output already lines up with the request.

    // Request fields travel on with the words.
    assign stage_valid  = req.valid;
    assign stage_source = req.source;
    assign stage_gated  = req.gated;

endmodule

/* rtl/read_req_if.sv */
// ========================================
// Decoded read request
// ========================================

interface read_req_if;
    import io_types_pkg::*;

    logic         valid;     // a read was accepted on the last edge.
    read_source_e source;    // RAM or port read.
    port_index_t  port;      // addressed port inside the window.
    addr_t        ram_addr;  // raw address of the read.
    logic         gated;     // io_ready was low when the address came in.

    // Decode fills the request on the edge it accepts the read.
    modport decode (
        output valid,
        output source,
        output port,
        output ram_addr,
        output gated
    );

    // Select turns it into a strobe and a word in the following cycle.
    modport select (
        input valid,
        input source,
        input port,
        input ram_addr,
        input gated
    );

endinterface

/* verif/io_read_chk.sv */
// ========================================
// I/O read protocol assertions
// ========================================

module io_read_chk (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     read_valid,
    input  io_types_pkg::port_mask_t port_read,
    input  logic                     read_data_valid
);

    int failures = 0;  // count of failed assertions.

    // At most one port is popped per cycle.
    strobe_onehot : assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(port_read))
        else begin
            $error("port_read has more than one port selected");
            failures++;
        end

    // A strobe always belongs to a read accepted on the edge before.
    strobe_after_read : assert property (@(posedge clock) disable iff (!rst_n)
        (|port_read) |-> $past(read_valid && rst_n))
        else begin
            $error("port_read pulsed without a read accepted one cycle earlier");
            failures++;
        end

    // ========================================
    // Result latency
    // ========================================

    valid_follows_read : assert property (@(posedge clock) disable iff (!rst_n)
        read_valid |-> ##2 read_data_valid)
        else begin
            $error("read_data_valid missing two cycles after a read");
            failures++;
        end

    valid_has_read : assert property (@(posedge clock) disable iff (!rst_n)
        read_data_valid |-> $past(read_valid, 2))
        else begin
            $error("read_data_valid without a read two cycles earlier");
            failures++;
        end

endmodule

bind io_read_top io_read_chk chk (
    .clock           (clock),
    .rst_n           (rst_n),
    .read_valid      (read_valid),
    .port_read       (port_read),
    .read_data_valid (read_data_valid)
);

/* verif/io_read_monitor.sv */
// ========================================
// I/O read reference monitor
// ========================================

module io_read_monitor (
    input  logic                                                clock,
    input  logic                                                rst_n,
    input  logic                                                read_valid,
    input  io_types_pkg::addr_t                                 read_addr,
    input  logic                                                io_ready,
    input  logic [io_map_pkg::port_count*io_map_pkg::word_width-1:0] port_data,
    input  logic                                                ram_write,
    input  io_types_pkg::addr_t                                 ram_write_addr,
    input  io_types_pkg::word_t                                 ram_write_data,
    input  logic                                                expected_ready,
    input  logic                                                port_ready_masked,
    input  io_types_pkg::port_mask_t                            port_read,
    input  io_types_pkg::word_t                                 read_data,
    input  logic                                                read_data_valid,
    output int                                                  data_errors,
    output int                                                  strobe_errors,
    output int                                                  flag_errors,
    output int                                                  timing_errors,
    output logic                                                idle
);
    import io_map_pkg::*;
    import io_types_pkg::*;

    word_t        shadow_ram [0:(2**addr_width)-1];  // RAM contents seen from the write port.
    word_t        expect_data_q [$];
    int unsigned  expect_due_q [$];                  // cycle each result must show up in.
    int unsigned  cycle;
    logic         pend_valid;                        // read seen in the previous cycle.
    read_source_e pend_source;
    logic         pend_gated;
    port_index_t  pend_port;
    word_t        pend_ram_word;

    // Inputs change on the rising edge, so everything is sampled on the falling one.
    always @(negedge clock) begin
        logic       expect_valid;
        word_t      expected;
        word_t      word;
        port_mask_t strobe_expect;
        if (rst_n !== 1'b1) begin
            cycle = 0;
            pend_valid = 1'b0;
            expect_data_q.delete();
            expect_due_q.delete();
            data_errors = 0;
            strobe_errors = 0;
            flag_errors = 0;
            timing_errors = 0;
        end else begin
            cycle = cycle + 1;

            // ========================================
            // Result check
            // ========================================
            expect_valid = (expect_due_q.size() != 0) && (expect_due_q[0] == cycle);
            if (read_data_valid !== expect_valid) begin
                timing_errors++;
                $display("[FAIL] %0t: read_data_valid is %b, expected %b",
                         $time, read_data_valid, expect_valid);
            end
            if (expect_valid) begin
                expected = expect_data_q.pop_front();
                void'(expect_due_q.pop_front());
                if (read_data !== expected) begin
                    data_errors++;
                    $display("[FAIL] %0t: read_data is %h, expected %h",
                             $time, read_data, expected);
                end
            end

            // Strobe cycle of the read seen one cycle ago.
            strobe_expect = '0;
            if (pend_valid) begin
                if (pend_source == source_io && !pend_gated) begin
                    strobe_expect[pend_port] = 1'b1;
                end
                if (pend_gated) begin
                    word = '0;
                end else if (pend_source == source_io) begin
                    word = port_data[pend_port*word_width +: word_width];
                end else begin
                    word = pend_ram_word;
                end
                expect_data_q.push_back(word);
                expect_due_q.push_back(cycle + read_latency - 1);  // address came a cycle ago.
            end
            if (port_read !== strobe_expect) begin
                strobe_errors++;
                $display("[FAIL] %0t: port_read is %b, expected %b",
                         $time, port_read, strobe_expect);
            end

            // ========================================
            // New request
            // ========================================
            pend_valid = read_valid;
            if (read_valid) begin
                if (port_ready_masked !== expected_ready) begin
                    flag_errors++;
                    $display("[FAIL] %0t: port_ready_masked is %b, expected %b at address %0d",
                             $time, port_ready_masked, expected_ready, read_addr);
                end
                pend_source = (read_addr >= port_base_addr) ? source_io : source_ram;
                pend_port = port_index_t'(read_addr - port_base_addr);
                pend_gated = !io_ready;
                pend_ram_word = shadow_ram[read_addr];  // old word if written on this edge.
            end
            if (ram_write) begin
                shadow_ram[ram_write_addr] = ram_write_data;
            end
        end
        idle = !pend_valid && (expect_due_q.size() == 0);
    end

endmodule

/* verif/io_read_tb.sv */
// ========================================
// I/O read path testbench
// ========================================

module io_read_tb;
    import io_map_pkg::*;
    import io_types_pkg::*;

    localparam int clock_period = 20;
    localparam logic [31:0] random_seed = 32'he74a;

    typedef enum logic {
        op_write,
        op_read
    } op_e;

    typedef struct packed {
        op_e        op;
        addr_t      addr;
        word_t      wdata;
        logic       rdy;     // io_ready while the address is presented.
        port_mask_t full;
        logic       flag;    // expected port_ready_masked on reads.
    } entry_t;

    logic                             clock;
    logic                             rst_n;
    logic                             read_valid;
    addr_t                            read_addr;
    logic                             io_ready;
    port_mask_t                       port_full;
    logic [port_count*word_width-1:0] port_data;
    logic                             ram_write;
    addr_t                            ram_write_addr;
    word_t                            ram_write_data;
    logic                             expected_ready;
    logic                             port_ready_masked;
    port_mask_t                       port_read;
    word_t                            read_data;
    logic                             read_data_valid;
    int                               data_errors;
    int                               strobe_errors;
    int                               flag_errors;
    int                               timing_errors;
    int                               total_errors;
    logic                             monitor_idle;
    entry_t                           stimulus [$];

    io_read_top DUT (
        .clock             (clock),
        .rst_n             (rst_n),
        .read_valid        (read_valid),
        .read_addr         (read_addr),
        .io_ready          (io_ready),
        .port_full         (port_full),
        .port_data         (port_data),
        .ram_write         (ram_write),
        .ram_write_addr    (ram_write_addr),
        .ram_write_data    (ram_write_data),
        .port_ready_masked (port_ready_masked),
        .port_read         (port_read),
        .read_data         (read_data),
        .read_data_valid   (read_data_valid)
    );

    io_read_monitor monitor (
        .clock             (clock),
        .rst_n             (rst_n),
        .read_valid        (read_valid),
        .read_addr         (read_addr),
        .io_ready          (io_ready),
        .port_data         (port_data),
        .ram_write         (ram_write),
        .ram_write_addr    (ram_write_addr),
        .ram_write_data    (ram_write_data),
        .expected_ready    (expected_ready),
        .port_ready_masked (port_ready_masked),
        .port_read         (port_read),
        .read_data         (read_data),
        .read_data_valid   (read_data_valid),
        .data_errors       (data_errors),
        .strobe_errors     (strobe_errors),
        .flag_errors       (flag_errors),
        .timing_errors     (timing_errors),
        .idle              (monitor_idle)
    );

    function automatic word_t random_word();
        logic [31:0] bits;
        bits = $urandom;
        return bits[word_width-1:0];
    endfunction

    task automatic add_write(input addr_t addr, input word_t data);
        stimulus.push_back(entry_t'{op_write, addr, data, 1'b1, 4'b0000, 1'b1});
    endtask

    task automatic add_read(input addr_t addr, input logic rdy, input port_mask_t full,
                            input logic flag);
        stimulus.push_back(entry_t'{op_read, addr, 16'h0000, rdy, full, flag});
    endtask

    // ========================================
    // Stimulus table
    // ========================================

    task automatic build_table();
        add_write(10'd10, 16'h1234);
        add_write(10'd11, 16'hbeef);
        add_write(10'd500, 16'h0f0f);
        add_write(10'd1019, 16'ha5a5);
        add_write(10'd1020, 16'hdead);                 // hidden behind port 0.
        add_read(10'd10, 1'b1, 4'b0000, 1'b1);
        add_write(10'd12, 16'h7777);
        add_read(10'd12, 1'b1, 4'b0000, 1'b1);         // written on the edge before.
        add_read(10'd11, 1'b1, 4'b1111, 1'b1);
        add_read(10'd500, 1'b1, 4'b0000, 1'b1);
        add_read(10'd1019, 1'b1, 4'b1111, 1'b1);       // last RAM word below the ports.
        add_read(10'd1020, 1'b1, 4'b0001, 1'b1);
        add_read(10'd1021, 1'b1, 4'b0001, 1'b0);
        add_read(10'd1022, 1'b1, 4'b0100, 1'b1);
        add_read(10'd1023, 1'b1, 4'b0111, 1'b0);
        add_read(10'd1023, 1'b1, 4'b1000, 1'b1);       // the port pops again and shows a new word.
        add_read(10'd1021, 1'b0, 4'b0010, 1'b1);       // held back so no strobe.
        add_read(10'd10, 1'b0, 4'b1111, 1'b1);
        add_write(10'd10, 16'h5555);
        add_read(10'd10, 1'b1, 4'b0000, 1'b1);
        add_read(10'd1020, 1'b1, 4'b1110, 1'b0);
        add_read(10'd1020, 1'b1, 4'b1111, 1'b1);
    endtask

    task automatic watchdog(input int entries);
        #(entries * 4 * clock_period + 200);
        $display("Run timed out before all reads returned a result.");
        $display("Regression failed");
        $finish;
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Each strobe pops the port's word and the port loads a fresh one.
    initial begin
        void'($urandom(random_seed));
        for (int p = 0; p < port_count; p++) begin
            port_data[p*word_width +: word_width] = random_word();
        end
        forever begin
            @(posedge clock);
            for (int p = 0; p < port_count; p++) begin
                if (port_read[p]) begin
                    port_data[p*word_width +: word_width] <= random_word();
                end
            end
        end
    end

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        rst_n          = 1'b0;
        read_valid     = 1'b0;
        read_addr      = '0;
        io_ready       = 1'b0;
        port_full      = '0;
        ram_write      = 1'b0;
        ram_write_addr = '0;
        ram_write_data = '0;
        expected_ready = 1'b1;
        build_table();
        fork
            watchdog(stimulus.size());
        join_none
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < stimulus.size(); i++) begin
            @(posedge clock);
            read_valid     <= (stimulus[i].op == op_read);
            read_addr      <= stimulus[i].addr;
            ram_write      <= (stimulus[i].op == op_write);
            ram_write_addr <= stimulus[i].addr;
            ram_write_data <= stimulus[i].wdata;
            io_ready       <= stimulus[i].rdy;
            port_full      <= stimulus[i].full;
            expected_ready <= stimulus[i].flag;
        end
        @(posedge clock);
        read_valid <= 1'b0;
        ram_write  <= 1'b0;
        while (monitor_idle !== 1'b1) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);  // catch any stray valid pulse.
        total_errors = data_errors + strobe_errors + flag_errors + timing_errors
                       + DUT.chk.failures;
        $display("Errors: data %0d, strobe %0d, flag %0d, timing %0d, assertions %0d",
                 data_errors, strobe_errors, flag_errors, timing_errors, DUT.chk.failures);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
